//--- hdl/soc_ctrl_pkg.sv
// ------------------------------------------------
// SoC control shared definitions
// Bus widths, address map, boot ROM word rule and
// the request/response types of the control port
// ------------------------------------------------

package soc_ctrl_pkg;

  // ------------------------------------------------
  // Bus widths
  // ------------------------------------------------
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;

  // ------------------------------------------------
  // Address map
  // ------------------------------------------------
  // Boot ROM window, 64 words of 4 bytes
  localparam addr_t       rom_base     = 32'h0001_0000;
  localparam int unsigned rom_words    = 64;

  // CLINT window holds the two 64-bit timer registers
  localparam addr_t       clint_base   = 32'h0200_0000;
  localparam addr_t       clint_length = 32'h0000_0010;

  // Timer register offsets inside the CLINT window
  localparam logic [3:0]  off_mtime_lo    = 4'h0;
  localparam logic [3:0]  off_mtime_hi    = 4'h4;
  localparam logic [3:0]  off_mtimecmp_lo = 4'h8;
  localparam logic [3:0]  off_mtimecmp_hi = 4'hc;

  // Upper half of every boot ROM word
  localparam logic [15:0] rom_tag = 16'hb007;

  // ------------------------------------------------
  // Port types
  // ------------------------------------------------
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    tgt_rom,
    tgt_clint,
    tgt_none
  } target_e;

endpackage

//--- hdl/boot_rom.sv
// ------------------------------------------------
// Boot ROM
// Combinational lookup of the fixed word pattern
// ------------------------------------------------

`timescale 1ns/1ns

module boot_rom (
  input  logic [5:0]          rom_index_i,
  output soc_ctrl_pkg::data_t rdata_o
);
  import soc_ctrl_pkg::*;

  localparam int unsigned index_width = 6;
  localparam int unsigned pad_width   = 16 - index_width;

  // ------------------------------------------------
  // Content rule
  // ------------------------------------------------
  // Tag in the upper half, word index in the lower half
  function automatic data_t rom_word(input logic [index_width-1:0] idx);
    data_t word;
    word = {rom_tag, {pad_width{1'b0}}, idx};
    return word;
  endfunction

  // Zero latency read
  always_comb begin
    rdata_o = rom_word(rom_index_i);
  end

endmodule

//--- hdl/bus_decoder.sv
// ------------------------------------------------
// Bus decoder
// Matches the request against the address rules,
// strobes timer writes and registers the response
// ------------------------------------------------

`timescale 1ns/1ns

module bus_decoder (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   req_valid_i,
  input  soc_ctrl_pkg::bus_req_t req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output soc_ctrl_pkg::bus_rsp_t rsp_o,
  input  logic                   rsp_ready_i,
  output logic [5:0]             rom_index_o,
  input  soc_ctrl_pkg::data_t    rom_rdata_i,
  output logic                   clint_we_o,
  output soc_ctrl_pkg::bus_req_t clint_req_o,
  input  soc_ctrl_pkg::data_t    clint_rdata_i
);
  import soc_ctrl_pkg::*;

  typedef struct packed {
    target_e idx;
    addr_t   start_addr;
    addr_t   end_addr;
  } rule_t;

  localparam addr_t       rom_length = addr_t'(rom_words * 4);
  localparam int unsigned num_rules  = 2;

  // Half-open windows [start_addr, end_addr)
  localparam rule_t addr_map [num_rules] = '{
    '{idx: tgt_rom,   start_addr: rom_base,   end_addr: rom_base + rom_length},
    '{idx: tgt_clint, start_addr: clint_base, end_addr: clint_base + clint_length}
  };

  target_e  target;
  logic     accept;
  logic     err;
  data_t    sel_rdata;
  logic     rsp_valid_q;
  bus_rsp_t rsp_q;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  always_comb begin
    target = tgt_none;
    for (int i = 0; i < num_rules; i++) begin
      if (req_i.addr >= addr_map[i].start_addr && req_i.addr < addr_map[i].end_addr) begin
        target = addr_map[i].idx;
      end
    end
  end

  // ROM is read only
  assign err = (target == tgt_none) || (target == tgt_rom && req_i.we);

  always_comb begin
    case (target)
      tgt_rom:   sel_rdata = rom_rdata_i;
      tgt_clint: sel_rdata = clint_rdata_i;
      default:   sel_rdata = '0;
    endcase
  end

  // Targets see the live request, data comes back in the same cycle
  assign rom_index_o = req_i.addr[7:2];
  assign clint_req_o = req_i;

  // Single item in flight, a taken response frees the slot at once
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;
  assign clint_we_o  = accept && (target == tgt_clint) && req_i.we;

  // ------------------------------------------------
  // Response register
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Timer writes return the register value seen before the write
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.rdata <= err ? '0 : sel_rdata;
      rsp_q.err   <= err;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- hdl/clint_timer.sv
// ------------------------------------------------
// Machine timer
// mtime/mtimecmp pair advanced by the divided RTC,
// raises the timer interrupt on mtime >= mtimecmp
// ------------------------------------------------

`timescale 1ns/1ns

module clint_timer (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   rtc_i,
  input  logic                   we_i,
  input  soc_ctrl_pkg::bus_req_t req_i,
  output soc_ctrl_pkg::data_t    rdata_o,
  output logic                   timer_irq_o
);
  import soc_ctrl_pkg::*;

  logic [1:0]  rtc_sync_q;
  logic        rtc_prev_q;
  logic        rtc_div_q;
  logic        rtc_rise;
  logic        mtime_tick;
  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtimecmp_d;
  logic        timer_irq_q;

  // ------------------------------------------------
  // RTC synchronizer and divide by two
  // ------------------------------------------------
  assign rtc_rise = rtc_sync_q[1] && !rtc_prev_q;
  // Divided bit goes high on this edge
  assign mtime_tick = rtc_rise && !rtc_div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= !rtc_div_q;
      end
    end
  end

  // ------------------------------------------------
  // Timer registers
  // ------------------------------------------------
  // A written half overrides the increment
  always_comb begin
    mtime_d    = mtime_q + 64'(mtime_tick);
    mtimecmp_d = mtimecmp_q;
    if (we_i) begin
      case (req_i.addr[3:0])
        off_mtime_lo:    mtime_d[31:0]     = req_i.wdata;
        off_mtime_hi:    mtime_d[63:32]    = req_i.wdata;
        off_mtimecmp_lo: mtimecmp_d[31:0]  = req_i.wdata;
        off_mtimecmp_hi: mtimecmp_d[63:32] = req_i.wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_q <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // Read word by offset, holes read as zero
  always_comb begin
    case (req_i.addr[3:0])
      off_mtime_lo:    rdata_o = mtime_q[31:0];
      off_mtime_hi:    rdata_o = mtime_q[63:32];
      off_mtimecmp_lo: rdata_o = mtimecmp_q[31:0];
      off_mtimecmp_hi: rdata_o = mtimecmp_q[63:32];
      default:         rdata_o = '0;
    endcase
  end

  assign timer_irq_o = timer_irq_q;

endmodule

//--- hdl/debug_gate.sv
// ------------------------------------------------
// Debug request gate
// Blocks external debug requests for a fixed time
// after reset so boot code can run first
// ------------------------------------------------

`timescale 1ns/1ns

module debug_gate #(
  parameter int unsigned delay_cycles = 500
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned cnt_width = (delay_cycles > 0) ? $clog2(delay_cycles + 1) : 1;

  logic [cnt_width-1:0] cnt_q;
  logic                 cnt_done;

  assign cnt_done = (cnt_q == '0);

  // Count down once per cycle and stop at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= cnt_width'(delay_cycles);
    end else if (!cnt_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = cnt_done && debug_req_i;

endmodule

//--- hdl/soc_ctrl_top.sv
// ------------------------------------------------
// SoC control top level
// Bus decoder, boot ROM, machine timer and the
// debug request gate behind one request port
// ------------------------------------------------

`timescale 1ns/1ns

module soc_ctrl_top #(
  parameter int unsigned dbg_delay_cycles = 500
) (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   rtc_i,
  // Request port
  input  logic                   req_valid_i,
  input  soc_ctrl_pkg::bus_req_t req_i,
  output logic                   req_ready_o,
  // Response port
  output logic                   rsp_valid_o,
  output soc_ctrl_pkg::bus_rsp_t rsp_o,
  input  logic                   rsp_ready_i,
  // Interrupt and debug
  output logic                   timer_irq_o,
  input  logic                   debug_req_i,
  output logic                   debug_req_o
);
  import soc_ctrl_pkg::*;

  logic [5:0] rom_index;
  data_t      rom_rdata;
  data_t      clint_rdata;
  logic       clint_we;
  bus_req_t   clint_req;

  // ------------------------------------------------
  // Bus decode and targets
  // ------------------------------------------------
  bus_decoder i_bus_decoder (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_valid_i   ( req_valid_i ),
    .req_i         ( req_i       ),
    .req_ready_o   ( req_ready_o ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_o         ( rsp_o       ),
    .rsp_ready_i   ( rsp_ready_i ),
    .rom_index_o   ( rom_index   ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_we_o    ( clint_we    ),
    .clint_req_o   ( clint_req   ),
    .clint_rdata_i ( clint_rdata )
  );

  boot_rom i_boot_rom (
    .rom_index_i ( rom_index ),
    .rdata_o     ( rom_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .we_i        ( clint_we    ),
    .req_i       ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o )
  );

  // ------------------------------------------------
  // Debug
  // ------------------------------------------------
  debug_gate #(
    .delay_cycles ( dbg_delay_cycles )
  ) i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- tb/soc_ctrl_checker.sv
// ------------------------------------------------
// Response checker
// Predicts every response from the address map and
// a timer model, compares and keeps the counts
// ------------------------------------------------

`timescale 1ns/1ns

module soc_ctrl_checker (
  input logic                   clk_i,
  input logic                   ndmreset_n,
  input logic                   rtc_i,
  input logic                   req_valid_i,
  input soc_ctrl_pkg::bus_req_t req_i,
  input logic                   req_ready_i,
  input logic                   rsp_valid_i,
  input soc_ctrl_pkg::bus_rsp_t rsp_i,
  input logic                   rsp_ready_i
);
  import soc_ctrl_pkg::*;

  bus_rsp_t    exp_q[$];
  bus_rsp_t    exp_rsp;
  bus_rsp_t    held_rsp;
  logic        stalled;
  logic [63:0] mtime_m;
  logic [63:0] mtimecmp_m;
  logic        div_m;
  logic        rtc_seen;
  data_t       last_rdata;
  string       test_name = "none";
  int          test_errors = 0;
  int          total_checks = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  // Expected response from the address map and the timer model
  function automatic bus_rsp_t expected_rsp(input bus_req_t req);
    bus_rsp_t rsp;
    rsp = '{rdata: '0, err: 1'b1};
    if (req.addr >= rom_base && req.addr < rom_base + rom_words * 4) begin
      if (!req.we) begin
        rsp.err   = 1'b0;
        rsp.rdata = {rom_tag, 16'((req.addr - rom_base) >> 2)};
      end
    end else if (req.addr >= clint_base && req.addr < clint_base + clint_length) begin
      // Timer writes see the register before the write lands
      rsp.err = 1'b0;
      case (req.addr[3:0])
        off_mtime_lo:    rsp.rdata = mtime_m[31:0];
        off_mtime_hi:    rsp.rdata = mtime_m[63:32];
        off_mtimecmp_lo: rsp.rdata = mtimecmp_m[31:0];
        off_mtimecmp_hi: rsp.rdata = mtimecmp_m[63:32];
        default:         rsp.rdata = '0;
      endcase
    end
    return rsp;
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("Test %s finished with %0d errors", test_name, test_errors);
  endtask

  task automatic report_error(input string text);
    test_errors++;
    total_errors++;
    $display("Error in test %s: %s", test_name, text);
  endtask

  task automatic check_value(input string what, input data_t exp, input data_t act);
    total_checks++;
    if (act !== exp) begin
      test_errors++;
      total_errors++;
      $display("Fail %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_totals();
    if (exp_q.size() != 0)
      report_error($sformatf("%0d responses never arrived", exp_q.size()));
    $display("Totals: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errors);
  endtask

  // ------------------------------------------------
  // Port monitor
  // ------------------------------------------------
  always @(posedge clk_i) begin
    if (!ndmreset_n) begin
      mtime_m    = '0;
      mtimecmp_m = '1;
      div_m      = 1'b0;
      rtc_seen   = 1'b0;
      stalled    = 1'b0;
      exp_q.delete();
    end else begin
      // mtime advances on every second RTC rising edge
      if (rtc_i && !rtc_seen) begin
        if (!div_m)
          mtime_m = mtime_m + 64'd1;
        div_m = !div_m;
      end
      rtc_seen = rtc_i;
      if (stalled && !rsp_valid_i)
        report_error("response withdrawn before it was taken");
      else if (stalled && rsp_i !== held_rsp)
        report_error("response changed while stalled");
      // Request port must wait while a response is held off
      if (rsp_valid_i && !rsp_ready_i && req_ready_i)
        report_error("request port ready while a response was stalled");
      if (!rsp_valid_i && !req_ready_i)
        report_error("request port not ready with no response pending");
      if (rsp_valid_i && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          report_error("response with no request in flight");
        end else begin
          exp_rsp = exp_q.pop_front();
          total_checks++;
          if (rsp_i !== exp_rsp) begin
            test_errors++;
            total_errors++;
            $display("Fail %s: expected rdata %h err %b, actual rdata %h err %b",
                     test_name, exp_rsp.rdata, exp_rsp.err, rsp_i.rdata, rsp_i.err);
          end
          last_rdata = rsp_i.rdata;
        end
      end
      stalled  = rsp_valid_i && !rsp_ready_i;
      held_rsp = rsp_i;
      if (req_valid_i && req_ready_i) begin
        exp_q.push_back(expected_rsp(req_i));
        if (req_i.we && req_i.addr >= clint_base && req_i.addr < clint_base + clint_length) begin
          case (req_i.addr[3:0])
            off_mtime_lo:    mtime_m[31:0]     = req_i.wdata;
            off_mtime_hi:    mtime_m[63:32]    = req_i.wdata;
            off_mtimecmp_lo: mtimecmp_m[31:0]  = req_i.wdata;
            off_mtimecmp_hi: mtimecmp_m[63:32] = req_i.wdata;
            default: ;
          endcase
        end
      end
    end
  end

endmodule

//--- tb/tb_soc_ctrl.sv
// ------------------------------------------------
// SoC control testbench
// Drives the request port, RTC and debug request
// ------------------------------------------------

`timescale 1ns/1ns

module tb_soc_ctrl;
  import soc_ctrl_pkg::*;

  localparam int unsigned dbg_delay    = 40;
  localparam int unsigned num_requests = 54;
  localparam int unsigned rtc_edges    = 20;
  // Test lengths added up, then doubled
  localparam int unsigned max_cycles = 2 * (num_requests * 6 + rtc_edges * 14 + dbg_delay);

  logic     clk;
  logic     ndmreset_n;
  logic     rtc;
  logic     req_valid;
  bus_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  bus_rsp_t rsp;
  logic     rsp_ready;
  logic     timer_irq;
  logic     dbg_req_in;
  logic     dbg_req_out;
  integer   seed;
  int       cycles = 0;

  soc_ctrl_top #(
    .dbg_delay_cycles ( dbg_delay )
  ) i_soc_ctrl_top (
    .clk_i       ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc         ),
    .req_valid_i ( req_valid   ),
    .req_i       ( req         ),
    .req_ready_o ( req_ready   ),
    .rsp_valid_o ( rsp_valid   ),
    .rsp_o       ( rsp         ),
    .rsp_ready_i ( rsp_ready   ),
    .timer_irq_o ( timer_irq   ),
    .debug_req_i ( dbg_req_in  ),
    .debug_req_o ( dbg_req_out )
  );

  soc_ctrl_checker i_checker (
    .clk_i       ( clk        ),
    .ndmreset_n  ( ndmreset_n ),
    .rtc_i       ( rtc        ),
    .req_valid_i ( req_valid  ),
    .req_i       ( req        ),
    .req_ready_i ( req_ready  ),
    .rsp_valid_i ( rsp_valid  ),
    .rsp_i       ( rsp        ),
    .rsp_ready_i ( rsp_ready  )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // One request, then the response held off for 0 to 3 cycles
  task automatic bus_access(input addr_t addr, input logic we, input data_t wdata);
    int stall;
    req_valid = 1'b1;
    req       = '{addr: addr, we: we, wdata: wdata};
    while (!req_ready)
      @(negedge clk);
    @(negedge clk);
    req_valid = 1'b0;
    stall     = $unsigned($random(seed)) % 4;
    repeat (stall) @(negedge clk);
    rsp_ready = 1'b1;
    while (!rsp_valid)
      @(negedge clk);
    @(negedge clk);
    rsp_ready = 1'b0;
  endtask

  task automatic toggle_rtc(input int edges);
    repeat (edges) begin
      rtc = 1'b1;
      repeat (7) @(negedge clk);
      rtc = 1'b0;
      repeat (7) @(negedge clk);
    end
  endtask

  initial begin
    addr_t addr;
    seed       = 32'h03d65afe;
    ndmreset_n = 1'b0;
    rtc        = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    rsp_ready  = 1'b0;
    dbg_req_in = 1'b1;
    repeat (16) @(negedge clk);
    ndmreset_n = 1'b1;

    i_checker.start_test("reset");
    i_checker.check_value("rsp_valid_o", 0, rsp_valid);
    i_checker.check_value("timer_irq_o", 0, timer_irq);
    i_checker.check_value("debug_req_o", 0, dbg_req_out);
    i_checker.check_value("req_ready_o", 1, req_ready);
    i_checker.end_test();

    i_checker.start_test("debug gate");
    for (int k = 1; k <= dbg_delay + 5; k++) begin
      @(negedge clk);
      i_checker.check_value($sformatf("debug_req_o cycle %0d", k), k >= dbg_delay, dbg_req_out);
    end
    i_checker.end_test();

    i_checker.start_test("rom");
    repeat (20) begin
      addr = rom_base + ((32'($random(seed)) & 32'h3f) << 2);
      bus_access(addr, 1'b0, '0);
    end
    bus_access(rom_base + 32'h8, 1'b1, 32'($random(seed)));
    bus_access(rom_base + 32'hfc, 1'b1, 32'($random(seed)));
    i_checker.end_test();

    i_checker.start_test("unmapped");
    bus_access(rom_base + 32'h100, 1'b0, '0);
    bus_access(clint_base + clint_length, 1'b0, '0);
    repeat (14) begin
      // Top bit set keeps the address above both windows
      addr = 32'($random(seed)) | 32'h8000_0000;
      bus_access(addr, 1'($random(seed)), 32'($random(seed)));
    end
    i_checker.end_test();

    i_checker.start_test("timer");
    for (int i = 0; i < 4; i++) begin
      bus_access(clint_base + 4 * i, 1'b1, 32'($random(seed)));
      bus_access(clint_base + 4 * i, 1'b0, '0);
    end
    bus_access(clint_base + off_mtime_hi, 1'b1, '0);
    bus_access(clint_base + off_mtime_lo, 1'b1, 32'h0000_1000);
    bus_access(clint_base + off_mtimecmp_hi, 1'b1, '0);
    bus_access(clint_base + off_mtimecmp_lo, 1'b1, 32'h0000_0800);
    repeat (2) @(negedge clk);
    i_checker.check_value("timer_irq_o with mtimecmp below mtime", 1, timer_irq);
    bus_access(clint_base + off_mtimecmp_lo, 1'b1, 32'h0000_2000);
    repeat (2) @(negedge clk);
    i_checker.check_value("timer_irq_o with mtimecmp above mtime", 0, timer_irq);
    i_checker.end_test();

    i_checker.start_test("rtc");
    bus_access(clint_base + off_mtime_lo, 1'b1, '0);
    bus_access(clint_base + off_mtime_hi, 1'b1, '0);
    toggle_rtc(rtc_edges);
    repeat (10) @(negedge clk);
    bus_access(clint_base + off_mtime_lo, 1'b0, '0);
    i_checker.check_value("mtime_lo after rtc edges", 10, i_checker.last_rdata);
    i_checker.end_test();

    i_checker.report_totals();
    if (i_checker.total_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial begin
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- all.f
hdl/soc_ctrl_pkg.sv
hdl/boot_rom.sv
hdl/bus_decoder.sv
hdl/clint_timer.sv
hdl/debug_gate.sv
hdl/soc_ctrl_top.sv
tb/soc_ctrl_checker.sv
tb/tb_soc_ctrl.sv

//--- Bender.yml
package:
  name: soc_ctrl

sources:
  - hdl/soc_ctrl_pkg.sv
  - hdl/boot_rom.sv
  - hdl/bus_decoder.sv
  - hdl/clint_timer.sv
  - hdl/debug_gate.sv
  - hdl/soc_ctrl_top.sv
  - target: test
    files:
      - tb/soc_ctrl_checker.sv
      - tb/tb_soc_ctrl.sv
